/* hw/lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// Data and address width of the LC-3b datapath
`define LC3B_WORD_W 16

// TRAP vector table entries are words, so trapvect8 is scaled by two
`define LC3B_TRAP_SHIFT 1

// Longest memory wait the checkers tolerate
`define LC3B_MAX_WAIT 16

`endif

/* hw/lc3b_pkg.sv */
`default_nettype none

`include "lc3b_config.svh"

package lc3b_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;     // Register file index
	typedef logic [1:0] lc3b_mask;    // Bit 0 is the low byte lane

	// Operation carried down the back end
	typedef enum logic [2:0] {
		OP_ALU,   // No memory access
		OP_LDW,
		OP_LDB,
		OP_STW,
		OP_STB,
		OP_LDI,   // Pointer read, then word read
		OP_STI,   // Pointer read, then word write
		OP_TRAP   // Vector table read
	} mem_op_t;

	// EX/MEM slot contents
	typedef struct packed {
		mem_op_t  op;
		lc3b_word alu_out;    // Address or ALU result
		lc3b_word srcb;       // Store data
		lc3b_word pc;
		lc3b_reg  dest;
		logic [7:0] trapvect8;
	} ex_mem_t;

	// MEM/WB slot contents
	typedef struct packed {
		mem_op_t  op;
		lc3b_word result;     // Load data, ALU value or trap target
		lc3b_reg  dest;
		lc3b_word pc;
	} mem_wb_t;

endpackage : lc3b_pkg

`default_nettype wire

/* hw/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     load,
	input  logic     bubble,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= in_valid && !bubble;   // Bubble kills the slot
		end
	end

	// Payload only, the valid bit qualifies it
	always_ff @(posedge clk) begin
		if (load) begin
			out_data <= in_data;
		end
	end

	a_payload_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(out_data))
		else $error("pipe_reg: payload unknown while slot is valid");

endmodule : pipe_reg

`default_nettype wire

/* hw/indirect_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module indirect_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic active,     // Memory op in the slot
	input  logic indirect,   // LDI or STI
	input  logic mem_resp,
	output logic ptr_phase,
	output logic load_ptr,
	output logic seq_done
);

	logic step;

	// Any response to an indirect op flips the phase
	assign step = active && indirect && mem_resp;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr_phase <= 1'b0;
		end else if (step) begin
			ptr_phase <= !ptr_phase;
		end
	end

	assign load_ptr = step && !ptr_phase;   // First response carries the pointer

	// Direct ops finish on their only response, indirect ones on the second
	assign seq_done = active && mem_resp && (!indirect || ptr_phase);

	// Second access must be answered within the wait bound
	a_ptr_wait: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ptr_phase) |-> ##[0:`LC3B_MAX_WAIT] mem_resp)
		else $error("indirect_ctrl: no response in pointer phase");

endmodule : indirect_ctrl

`default_nettype wire

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module mem_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               valid,
	input  lc3b_pkg::mem_op_t  op,
	input  lc3b_pkg::lc3b_word alu_out,
	input  lc3b_pkg::lc3b_word srcb,
	input  lc3b_pkg::lc3b_word pc,
	input  logic [7:0]         trapvect8,
	input  lc3b_pkg::lc3b_word mem_rdata,
	input  logic               mem_resp,
	output logic               mem_read,
	output logic               mem_write,
	output lc3b_pkg::lc3b_word mem_addr,
	output lc3b_pkg::lc3b_word mem_wdata,
	output lc3b_pkg::lc3b_mask mem_wmask,
	output lc3b_pkg::lc3b_word result,
	output logic               done
);
	import lc3b_pkg::*;

	lc3b_word ptr_q;        // Pointer fetched by LDI/STI
	lc3b_word trap_addr;
	lc3b_word byte_data;
	logic     is_mem;
	logic     is_indirect;
	logic     ptr_phase;
	logic     load_ptr;
	logic     seq_done;

	assign is_mem      = valid && (op != OP_ALU);
	assign is_indirect = (op == OP_LDI) || (op == OP_STI);

	indirect_ctrl indirect_ctrl_i (
		.clk,
		.rst_n,
		.active   (is_mem),
		.indirect (is_indirect),
		.mem_resp,
		.ptr_phase,
		.load_ptr,
		.seq_done
	);

	always_ff @(posedge clk) begin
		if (load_ptr) begin
			ptr_q <= mem_rdata;
		end
	end

	assign trap_addr = lc3b_word'({8'h00, trapvect8}) << `LC3B_TRAP_SHIFT;

	always_comb begin
		if (op == OP_TRAP) begin
			mem_addr = trap_addr;
		end else if (ptr_phase) begin
			mem_addr = ptr_q;   // Second access goes through the pointer
		end else begin
			mem_addr = alu_out;
		end
	end

	// Strobes stay up until the response
	always_comb begin
		mem_read  = 1'b0;
		mem_write = 1'b0;
		if (valid) begin
			case (op)
				OP_LDW, OP_LDB, OP_LDI, OP_TRAP: mem_read = 1'b1;
				OP_STW, OP_STB: mem_write = 1'b1;
				OP_STI: begin
					mem_read  = !ptr_phase;
					mem_write = ptr_phase;
				end
				default: begin
					mem_read  = 1'b0;
					mem_write = 1'b0;
				end
			endcase
		end
	end

	// Byte store drives both lanes under a one-lane mask
	assign mem_wdata = (op == OP_STB) ? {srcb[7:0], srcb[7:0]} : srcb;
	assign mem_wmask = (op != OP_STB) ? lc3b_mask'(2'b11) :
	                   (mem_addr[0] ? lc3b_mask'(2'b10) : lc3b_mask'(2'b01));

	assign byte_data = mem_addr[0] ? {8'h00, mem_rdata[15:8]} : {8'h00, mem_rdata[7:0]};

	always_comb begin
		case (op)
			OP_LDW, OP_LDI, OP_TRAP: result = mem_rdata;
			OP_LDB: result = byte_data;   // Zero-extended lane
			default: result = alu_out;    // ALU value or store address
		endcase
	end

	assign done = valid && ((op == OP_ALU) || seq_done);

	// A pending access keeps its direction and address until memory answers
	a_rw_held: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read || mem_write) && !mem_resp |=>
			!(mem_read && mem_write) && $stable(mem_read) && $stable(mem_write) &&
			$stable(mem_addr))
		else $error("mem_stage: strobe changed before the response at pc %h", pc);

endmodule : mem_stage

`default_nettype wire

/* hw/wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module wb_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               valid,
	input  lc3b_pkg::mem_op_t  op,
	input  lc3b_pkg::lc3b_word result,
	input  lc3b_pkg::lc3b_reg  dest,
	input  lc3b_pkg::lc3b_word pc,
	output logic               wb_valid,
	output logic               wb_we,
	output lc3b_pkg::lc3b_reg  wb_dest,
	output lc3b_pkg::lc3b_word wb_data,
	output logic               wb_cc_we,
	output logic [2:0]         wb_cc,
	output logic               pc_redirect,
	output lc3b_pkg::lc3b_word pc_target
);
	import lc3b_pkg::*;

	logic       writes_result;
	logic       is_trap;
	logic [2:0] cc_next;

	assign is_trap = (op == OP_TRAP);
	assign writes_result = (op == OP_ALU) || (op == OP_LDW) || (op == OP_LDB) ||
	                       (op == OP_LDI);

	// n z p from the value written
	assign cc_next = {result[`LC3B_WORD_W-1],
	                  result == '0,
	                  !result[`LC3B_WORD_W-1] && (result != '0)};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid    <= 1'b0;
			wb_we       <= 1'b0;
			wb_cc_we    <= 1'b0;
			pc_redirect <= 1'b0;
		end else begin
			wb_valid    <= valid;   // Stores retire too
			wb_we       <= valid && (writes_result || is_trap);
			wb_cc_we    <= valid && writes_result;
			pc_redirect <= valid && is_trap;
		end
	end

	always_ff @(posedge clk) begin
		if (valid) begin
			wb_dest   <= is_trap ? lc3b_reg'(3'd7) : dest;   // R7 gets the return PC
			wb_data   <= is_trap ? pc : result;
			pc_target <= result;
			if (writes_result) begin
				wb_cc <= cc_next;
			end
		end
	end

endmodule : wb_stage

`default_nettype wire

/* hw/mem_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_backend (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ex_valid,
	input  lc3b_pkg::mem_op_t  ex_op,
	input  lc3b_pkg::lc3b_word ex_alu_out,
	input  lc3b_pkg::lc3b_word ex_srcb,
	input  lc3b_pkg::lc3b_word ex_pc,
	input  lc3b_pkg::lc3b_reg  ex_dest,
	input  logic [7:0]         ex_trapvect8,
	output logic               stall,
	output logic               mem_read,
	output logic               mem_write,
	output lc3b_pkg::lc3b_word mem_addr,
	output lc3b_pkg::lc3b_word mem_wdata,
	output lc3b_pkg::lc3b_mask mem_wmask,
	input  lc3b_pkg::lc3b_word mem_rdata,
	input  logic               mem_resp,
	output logic               wb_valid,
	output logic               wb_we,
	output lc3b_pkg::lc3b_reg  wb_dest,
	output lc3b_pkg::lc3b_word wb_data,
	output logic               wb_cc_we,
	output logic [2:0]         wb_cc,
	output logic               pc_redirect,
	output lc3b_pkg::lc3b_word pc_target
);
	import lc3b_pkg::*;

	ex_mem_t  ex_in;
	ex_mem_t  ex_q;
	logic     ex_q_valid;
	mem_wb_t  wb_in;
	mem_wb_t  wb_q;
	logic     wb_q_valid;
	lc3b_word mem_result;
	logic     mem_done;

	assign ex_in = '{op: ex_op, alu_out: ex_alu_out, srcb: ex_srcb, pc: ex_pc,
	                 dest: ex_dest, trapvect8: ex_trapvect8};

	assign stall = ex_q_valid && !mem_done;   // Memory op still waiting

	pipe_reg #(.payload_t(ex_mem_t)) ex_mem_i (
		.clk,
		.rst_n,
		.load      (!stall),
		.bubble    (1'b0),
		.in_valid  (ex_valid),
		.in_data   (ex_in),
		.out_valid (ex_q_valid),
		.out_data  (ex_q)
	);

	mem_stage mem_stage_i (
		.clk,
		.rst_n,
		.valid     (ex_q_valid),
		.op        (ex_q.op),
		.alu_out   (ex_q.alu_out),
		.srcb      (ex_q.srcb),
		.pc        (ex_q.pc),
		.trapvect8 (ex_q.trapvect8),
		.mem_rdata,
		.mem_resp,
		.mem_read,
		.mem_write,
		.mem_addr,
		.mem_wdata,
		.mem_wmask,
		.result    (mem_result),
		.done      (mem_done)
	);

	assign wb_in = '{op: ex_q.op, result: mem_result, dest: ex_q.dest, pc: ex_q.pc};

	// Loads every cycle, unfinished slot becomes a bubble
	pipe_reg #(.payload_t(mem_wb_t)) mem_wb_i (
		.clk,
		.rst_n,
		.load      (1'b1),
		.bubble    (stall),
		.in_valid  (ex_q_valid),
		.in_data   (wb_in),
		.out_valid (wb_q_valid),
		.out_data  (wb_q)
	);

	wb_stage wb_stage_i (
		.clk,
		.rst_n,
		.valid       (wb_q_valid),
		.op          (wb_q.op),
		.result      (wb_q.result),
		.dest        (wb_q.dest),
		.pc          (wb_q.pc),
		.wb_valid,
		.wb_we,
		.wb_dest,
		.wb_data,
		.wb_cc_we,
		.wb_cc,
		.pc_redirect,
		.pc_target
	);

endmodule : mem_backend

`default_nettype wire

/* sim/tb_data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_data_mem #(
	parameter int unsigned seed = 80
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               mem_read,
	input  logic               mem_write,
	input  lc3b_pkg::lc3b_word mem_addr,
	input  lc3b_pkg::lc3b_word mem_wdata,
	input  lc3b_pkg::lc3b_mask mem_wmask,
	output lc3b_pkg::lc3b_word mem_rdata,
	output logic               mem_resp
);
	import lc3b_pkg::*;

	lc3b_word mem [256];   // Indexed by byte address bits 8:1

	initial begin
		logic        busy;
		int unsigned wait_cnt;
		logic [7:0]  idx;
		busy = 1'b0;
		wait_cnt = 0;
		mem_rdata <= '0;
		mem_resp  <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'(i) ^ 8'hc3, 8'(i)};
		end
		void'($urandom(seed));
		forever begin
			@(posedge clk or negedge rst_n);
			if (!rst_n) begin
				busy = 1'b0;
				mem_resp <= 1'b0;
			end else begin
				mem_resp <= 1'b0;
				if (busy) begin
					if (wait_cnt == 0) begin
						idx = mem_addr[8:1];
						if (mem_write && mem_wmask[0]) begin
							mem[idx][7:0] = mem_wdata[7:0];
						end
						if (mem_write && mem_wmask[1]) begin
							mem[idx][15:8] = mem_wdata[15:8];
						end
						mem_rdata <= mem[idx];
						mem_resp  <= 1'b1;
						busy = 1'b0;
					end else begin
						wait_cnt = wait_cnt - 1;
					end
				end else if ((mem_read || mem_write) && !mem_resp) begin
					// A strobe still up in the response cycle is the finished access
					busy = 1'b1;
					wait_cnt = $urandom_range(3, 0);
				end
			end
		end
	end

endmodule : tb_data_mem

`default_nettype wire

/* sim/mem_backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_backend_tb;
	import lc3b_pkg::*;

	localparam int clk_half = 20;
	localparam int accept_limit = 40;
	localparam int drain_limit = 100;
	localparam int unsigned mem_seed = 80;

	typedef struct {
		mem_op_t    op;
		lc3b_word   alu_out;
		lc3b_word   srcb;
		lc3b_word   pc;
		lc3b_reg    dest;
		logic [7:0] tv;
	} row_t;

	// One expected retirement
	typedef struct {
		int         row;
		logic       we;
		lc3b_reg    dest;
		lc3b_word   data;
		logic       cc_we;
		logic [2:0] cc;
		logic       redirect;
		lc3b_word   target;
		logic       b2b;       // Retires the cycle after the previous row
	} exp_t;

	logic       clk;
	logic       rst_n;
	logic       ex_valid;
	mem_op_t    ex_op;
	lc3b_word   ex_alu_out;
	lc3b_word   ex_srcb;
	lc3b_word   ex_pc;
	lc3b_reg    ex_dest;
	logic [7:0] ex_trapvect8;
	logic       stall;
	logic       mem_read;
	logic       mem_write;
	lc3b_word   mem_addr;
	lc3b_word   mem_wdata;
	lc3b_mask   mem_wmask;
	lc3b_word   mem_rdata;
	logic       mem_resp;
	logic       wb_valid;
	logic       wb_we;
	lc3b_reg    wb_dest;
	lc3b_word   wb_data;
	logic       wb_cc_we;
	logic [2:0] wb_cc;
	logic       pc_redirect;
	lc3b_word   pc_target;

	row_t     rows[$];
	exp_t     exp_q[$];
	exp_t     head;
	lc3b_word ref_mem [256];   // Reference copy of data memory
	int       err_count = 0;
	int       timeouts = 0;
	int       retired = 0;
	int       cycle = 0;
	int       last_retire = 0;
	logic     rows_started = 1'b0;

	mem_backend mem_backend_i (.*);

	tb_data_mem #(.seed(mem_seed)) data_mem_i (.*);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// Negative, zero or positive as a two's complement word
	function automatic logic [2:0] cc_of(input lc3b_word v);
		logic [2:0] cc;
		if (v == 16'h0000) begin
			cc = 3'b010;
		end else if ($signed(v) < 0) begin
			cc = 3'b100;
		end else begin
			cc = 3'b001;
		end
		return cc;
	endfunction

	task automatic report_mismatch(input string msg);
		err_count++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	// Appends a row and predicts its retirement from the reference memory
	task automatic add_row(input mem_op_t op, input lc3b_word a, input lc3b_word b,
	                       input lc3b_reg dest, input logic [7:0] tv);
		row_t     row;
		exp_t     e;
		lc3b_word w;
		lc3b_word ta;
		row = '{op, a, b, 16'h3000 + 16'(2 * rows.size()), dest, tv};
		e = '{rows.size(), 1'b0, dest, a, 1'b0, 3'b000, 1'b0, 16'h0000, 1'b0};
		if (rows.size() > 0) begin
			e.b2b = (op == OP_ALU) && (rows[$].op == OP_ALU);
		end
		w = ref_mem[a[8:1]];
		ta = {7'b0, tv, 1'b0};   // Vector times two
		case (op)
			OP_ALU: e.data = a;
			OP_LDW: e.data = w;
			OP_LDB: e.data = {8'h00, a[0] ? w[15:8] : w[7:0]};
			OP_LDI: e.data = ref_mem[w[8:1]];   // w holds the pointer
			OP_STW: ref_mem[a[8:1]] = b;
			OP_STB: begin
				if (a[0]) begin
					ref_mem[a[8:1]][15:8] = b[7:0];
				end else begin
					ref_mem[a[8:1]][7:0] = b[7:0];
				end
			end
			OP_STI: ref_mem[w[8:1]] = b;
			OP_TRAP: begin
				e.we = 1'b1;
				e.dest = 3'd7;
				e.data = row.pc;
				e.redirect = 1'b1;
				e.target = ref_mem[ta[8:1]];
			end
		endcase
		if (op == OP_ALU || op == OP_LDW || op == OP_LDB || op == OP_LDI) begin
			e.we = 1'b1;
			e.cc_we = 1'b1;
			e.cc = cc_of(e.data);
		end
		rows.push_back(row);
		exp_q.push_back(e);
	endtask

	task automatic drive_row(input int r);
		ex_valid     <= 1'b1;
		ex_op        <= rows[r].op;
		ex_alu_out   <= rows[r].alu_out;
		ex_srcb      <= rows[r].srcb;
		ex_pc        <= rows[r].pc;
		ex_dest      <= rows[r].dest;
		ex_trapvect8 <= rows[r].tv;
	endtask

	// Retirement monitor on the falling edge
	always @(negedge clk) begin
		if (!rows_started && (mem_read || mem_write || stall || wb_valid)) begin
			report_mismatch("activity seen before the first row was applied");
		end
		if (stall && !(mem_read || mem_write)) begin
			report_mismatch("stall high with no memory access pending");
		end
		if (pc_redirect && !wb_valid) begin
			report_mismatch("pc_redirect without wb_valid");
		end
		if (wb_valid && exp_q.size() == 0) begin
			report_mismatch("retirement with no row outstanding");
		end else if (wb_valid) begin
			head = exp_q.pop_front();
			retired++;
			if (wb_we !== head.we) begin
				report_mismatch($sformatf("row %0d wb_we %b, expected %b",
				                          head.row, wb_we, head.we));
			end
			if (head.we && wb_dest !== head.dest) begin
				report_mismatch($sformatf("row %0d wb_dest %0d, expected %0d",
				                          head.row, wb_dest, head.dest));
			end
			if (head.we && wb_data !== head.data) begin
				report_mismatch($sformatf("row %0d wb_data %h, expected %h",
				                          head.row, wb_data, head.data));
			end
			if (wb_cc_we !== head.cc_we) begin
				report_mismatch($sformatf("row %0d wb_cc_we %b, expected %b",
				                          head.row, wb_cc_we, head.cc_we));
			end
			if (head.cc_we && wb_cc !== head.cc) begin
				report_mismatch($sformatf("row %0d wb_cc %b, expected %b",
				                          head.row, wb_cc, head.cc));
			end
			if (pc_redirect !== head.redirect) begin
				report_mismatch($sformatf("row %0d pc_redirect %b, expected %b",
				                          head.row, pc_redirect, head.redirect));
			end
			if (head.redirect && pc_target !== head.target) begin
				report_mismatch($sformatf("row %0d pc_target %h, expected %h",
				                          head.row, pc_target, head.target));
			end
			if (head.b2b && cycle != last_retire + 1) begin
				report_mismatch($sformatf("row %0d retired %0d cycles after the previous row",
				                          head.row, cycle - last_retire));
			end
			last_retire = cycle;
		end
	end

	initial begin : stimulus
		int   wait_cycles;
		logic accepted;
		rst_n        <= 1'b0;
		ex_valid     <= 1'b0;
		ex_op        <= OP_ALU;
		ex_alu_out   <= '0;
		ex_srcb      <= '0;
		ex_pc        <= '0;
		ex_dest      <= '0;
		ex_trapvect8 <= '0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = {8'(i) ^ 8'hc3, 8'(i)};   // Same preload as the memory model
		end
		add_row(OP_ALU, 16'h1234, 16'h0000, 3'd1, 8'h00);
		add_row(OP_ALU, 16'h0000, 16'h0000, 3'd2, 8'h00);
		add_row(OP_ALU, 16'h8001, 16'h0000, 3'd3, 8'h00);
		add_row(OP_ALU, 16'h7fff, 16'h0000, 3'd4, 8'h00);
		add_row(OP_LDW, 16'h0020, 16'h0000, 3'd1, 8'h00);
		add_row(OP_LDB, 16'h0031, 16'h0000, 3'd2, 8'h00);   // Odd address selects the high byte
		add_row(OP_LDB, 16'h0030, 16'h0000, 3'd3, 8'h00);
		add_row(OP_LDB, 16'h0000, 16'h0000, 3'd4, 8'h00);   // Zero byte
		add_row(OP_STW, 16'h0100, 16'ha5a5, 3'd0, 8'h00);
		add_row(OP_STB, 16'h0101, 16'h0012, 3'd0, 8'h00);
		add_row(OP_STB, 16'h0100, 16'hff34, 3'd0, 8'h00);
		add_row(OP_LDW, 16'h0100, 16'h0000, 3'd5, 8'h00);   // Merged word
		add_row(OP_STW, 16'h0040, 16'h0150, 3'd0, 8'h00);   // Pointer for LDI
		add_row(OP_LDI, 16'h0040, 16'h0000, 3'd6, 8'h00);
		add_row(OP_STW, 16'h0042, 16'h0160, 3'd0, 8'h00);
		add_row(OP_STI, 16'h0042, 16'hbeef, 3'd0, 8'h00);
		add_row(OP_LDW, 16'h0160, 16'h0000, 3'd7, 8'h00);
		add_row(OP_LDI, 16'h0042, 16'h0000, 3'd1, 8'h00);
		add_row(OP_TRAP, 16'h0000, 16'h0000, 3'd0, 8'h25);
		add_row(OP_ALU, 16'h0042, 16'h0000, 3'd2, 8'h00);
		add_row(OP_LDW, 16'h0042, 16'h0000, 3'd3, 8'h00);
		add_row(OP_ALU, 16'hfffe, 16'h0000, 3'd4, 8'h00);
		add_row(OP_ALU, 16'h0001, 16'h0000, 3'd5, 8'h00);
		add_row(OP_STB, 16'h0161, 16'h0080, 3'd0, 8'h00);
		add_row(OP_LDB, 16'h0161, 16'h0000, 3'd6, 8'h00);
		add_row(OP_TRAP, 16'h0000, 16'h0000, 3'd0, 8'h80);   // Vector hits stored word

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);   // Idle cycles before the first row
		rows_started = 1'b1;
		for (int r = 0; r < rows.size() && timeouts == 0; r++) begin
			drive_row(r);
			accepted = 1'b0;
			wait_cycles = 0;
			while (!accepted && timeouts == 0) begin
				@(negedge clk);
				if (!stall) begin
					accepted = 1'b1;
				end else if (wait_cycles >= accept_limit) begin
					$display("Timeout: row %0d was not accepted within %0d cycles",
					         r, accept_limit);
					timeouts++;
				end else begin
					wait_cycles++;
				end
			end
			@(posedge clk);   // Row taken at this edge
		end
		ex_valid <= 1'b0;
		wait_cycles = 0;
		while (exp_q.size() != 0 && timeouts == 0) begin
			@(posedge clk);
			if (wait_cycles >= drain_limit) begin
				$display("Timeout: %0d rows never retired", exp_q.size());
				timeouts++;
			end else begin
				wait_cycles++;
			end
		end
		repeat (4) @(posedge clk);   // Room for a stray extra retirement
		$display("Retired %0d of %0d rows, %0d errors, %0d timeouts",
		         retired, rows.size(), err_count, timeouts);
		if (err_count == 0 && timeouts == 0 && retired == rows.size()) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule : mem_backend_tb

`default_nettype wire

/* sources.f */
+incdir+hw
hw/lc3b_pkg.sv
hw/pipe_reg.sv
hw/indirect_ctrl.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/mem_backend.sv
sim/tb_data_mem.sv
sim/mem_backend_tb.sv

/* Makefile */
# Verilator build and run for the LC-3b memory back end

VERILATOR  ?= verilator
TOP        ?= mem_backend_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Simulation finished: FAIL
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
